// File: sim.f
source/wb_pkg.sv
source/lsu_pkg.sv
source/scalar_lsu.sv
source/vector_lsu.sv
source/wb_arbiter.sv
source/lsu_system.sv
sim/wb_mem_model.sv
sim/lsu_system_sva.sv
sim/tb_lsu_system.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_lsu_system
BUILD_DIR ?= build
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: run build lint clean

run: build
	./$(BUILD_DIR)/V$(TOP)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: sim/tb_lsu_system.sv
// Testbench for the memory subsystem
// Directed tests of both engines, clock, reset and timeout

`timescale 1ns/1ps

module tb_lsu_system import wb_pkg::*, lsu_pkg::*; ();

  localparam int unsigned MaxVecLen     = 64;
  localparam int unsigned TimeoutCycles = 20000;
  localparam logic [31:0] Seed          = 32'h407e_3aba;

  logic        clk;
  logic        rst;
  logic        scalar_cmd_valid;
  scalar_cmd_t scalar_cmd;
  logic        scalar_cmd_ready;
  logic        scalar_res_valid;
  scalar_res_t scalar_res;
  logic        vec_cmd_valid;
  vec_cmd_t    vec_cmd;
  logic        vec_cmd_ready;
  logic        vec_res_valid;
  vec_res_t    vec_res;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  int unsigned cycles = 0;

  lsu_system #(
    .MaxVecLen (MaxVecLen)
  ) lsu_system_inst (
    .clk_i              (clk),
    .rst_i              (rst),
    .scalar_cmd_valid_i (scalar_cmd_valid),
    .scalar_cmd_i       (scalar_cmd),
    .scalar_cmd_ready_o (scalar_cmd_ready),
    .scalar_res_valid_o (scalar_res_valid),
    .scalar_res_o       (scalar_res),
    .vec_cmd_valid_i    (vec_cmd_valid),
    .vec_cmd_i          (vec_cmd),
    .vec_cmd_ready_o    (vec_cmd_ready),
    .vec_res_valid_o    (vec_res_valid),
    .vec_res_o          (vec_res),
    .wb_req_o           (wb_req),
    .wb_rsp_i           (wb_rsp)
  );

  wb_mem_model mem_model_inst (
    .clk_i (clk),
    .rst_i (rst),
    .req_i (wb_req),
    .rsp_o (wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TimeoutCycles) begin
      stop_with_failure($sformatf("Timeout, the run exceeded %0d cycles", TimeoutCycles));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic expect_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      stop_with_failure($sformatf("[FAIL] %s = 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  // Preload value that differs at every address
  function automatic logic [31:0] marker_word(input logic [15:0] addr);
    return {16'hc3e1, addr};
  endfunction

  task automatic apply_reset();
    rst              <= 1'b1;
    scalar_cmd_valid <= 1'b0;
    vec_cmd_valid    <= 1'b0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
  endtask

  // Starts and ends on a rising edge, outputs sampled on falling edges
  task automatic scalar_access(input scalar_op_e op, input logic [15:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata);
    scalar_cmd_valid <= 1'b1;
    scalar_cmd       <= '{op: op, addr: addr, wdata: wdata};
    @(negedge clk);
    while (!scalar_cmd_ready) @(negedge clk);
    @(posedge clk);
    scalar_cmd_valid <= 1'b0;
    @(negedge clk);
    while (!scalar_res_valid) @(negedge clk);
    rdata = scalar_res.rdata;
    @(posedge clk);
  endtask

  task automatic vector_access(input vec_op_e op, input logic [15:0] base, input logic [7:0] len,
                               input logic [31:0] seed, output logic [31:0] sum);
    vec_cmd_valid <= 1'b1;
    vec_cmd       <= '{op: op, base: base, len: len, seed: seed};
    @(negedge clk);
    while (!vec_cmd_ready) @(negedge clk);
    @(posedge clk);
    vec_cmd_valid <= 1'b0;
    @(negedge clk);
    while (!vec_res_valid) @(negedge clk);
    sum = vec_res.sum;
    @(posedge clk);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_scalar_round_trip();
    logic [15:0] addr [8];
    logic [31:0] data [8];
    logic [31:0] rdata;
    for (int i = 0; i < 8; i++) begin
      addr[i] = 16'h0020 + 16'(i * 5);
      data[i] = $urandom;
      scalar_access(SCALAR_STORE, addr[i], data[i], rdata);
    end
    for (int i = 0; i < 8; i++) begin
      scalar_access(SCALAR_LOAD, addr[i], '0, rdata);
      expect_word("scalar_res_o", rdata, data[i]);
    end
  endtask

  task automatic test_vector_fill();
    logic [31:0] seed;
    logic [31:0] rdata;
    seed = $urandom;
    vector_access(VEC_FILL, 16'h0100, 8'd20, seed, rdata);
    expect_word("vec_res_o", rdata, '0);
    for (int i = 0; i < 20; i++) begin
      scalar_access(SCALAR_LOAD, 16'h0100 + 16'(i), '0, rdata);
      expect_word("scalar_res_o", rdata, seed + 32'(i));
    end
  endtask

  task automatic test_vector_sum();
    logic [31:0] word;
    logic [31:0] total;
    logic [31:0] sum;
    total = '0;
    for (int i = 0; i < 40; i++) begin
      word = $urandom;
      mem_model_inst.poke_word(16'h0200 + 16'(i), word);
      total += word;
    end
    vector_access(VEC_SUM, 16'h0200, 8'd40, '0, sum);
    expect_word("vec_res_o", sum, total);
  endtask

  task automatic test_length_clip();
    logic [15:0] base;
    logic [31:0] seed;
    logic [31:0] sum;
    base = 16'h0300;
    seed = $urandom;
    for (int i = 0; i <= MaxVecLen + 8; i++) begin
      mem_model_inst.poke_word(base + 16'(i), marker_word(base + 16'(i)));
    end
    vector_access(VEC_FILL, base, 8'(MaxVecLen + 8), seed, sum);
    expect_word("mem[base+MaxVecLen-1]", mem_model_inst.peek_word(base + 16'(MaxVecLen - 1)),
                seed + 32'(MaxVecLen - 1));
    expect_word("mem[base+MaxVecLen]", mem_model_inst.peek_word(base + 16'(MaxVecLen)),
                marker_word(base + 16'(MaxVecLen)));
  endtask

  // Two vector sums and a run of scalar stores started in the same cycle
  task automatic test_concurrent_traffic();
    logic [31:0] word;
    logic [31:0] exp_a;
    logic [31:0] exp_b;
    logic [31:0] got_a;
    logic [31:0] got_b;
    logic [31:0] store_val [12];
    int          stores_done;
    int          stores_at_a;
    int          stores_at_b;
    exp_a       = '0;
    exp_b       = '0;
    stores_done = 0;
    stores_at_a = 0;
    stores_at_b = 0;
    for (int i = 0; i < 48; i++) begin
      word = $urandom;
      mem_model_inst.poke_word(16'h0400 + 16'(i), word);
      if (i < 24) begin
        exp_a += word;
      end else begin
        exp_b += word;
      end
    end
    for (int i = 0; i < 12; i++) begin
      store_val[i] = $urandom;
    end
    fork
      begin
        vector_access(VEC_SUM, 16'h0400, 8'd24, '0, got_a);
        stores_at_a = stores_done;
        vector_access(VEC_SUM, 16'h0418, 8'd24, '0, got_b);
        stores_at_b = stores_done;
      end
      begin
        logic [31:0] rdata;
        for (int i = 0; i < 12; i++) begin
          scalar_access(SCALAR_STORE, 16'h0500 + 16'(i), store_val[i], rdata);
          stores_done++;
        end
      end
    join
    expect_word("vec_res_o", got_a, exp_a);
    expect_word("vec_res_o", got_b, exp_b);
    // Scalar store must slip in between the two vector runs
    assert (stores_at_b > stores_at_a) else begin
      stop_with_failure("No scalar store completed between the two vector runs");
    end
    for (int i = 0; i < 12; i++) begin
      expect_word("mem[0x500+i]", mem_model_inst.peek_word(16'h0500 + 16'(i)), store_val[i]);
    end
  endtask

  // Reset lands while both engines are busy
  task automatic test_reset_state();
    vec_cmd_valid <= 1'b1;
    vec_cmd       <= '{op: VEC_SUM, base: 16'h0600, len: 8'd40, seed: '0};
    @(negedge clk);
    while (!wb_req.cyc) @(negedge clk);
    @(posedge clk);
    vec_cmd_valid    <= 1'b0;
    scalar_cmd_valid <= 1'b1;
    scalar_cmd       <= '{op: SCALAR_LOAD, addr: 16'h0700, wdata: '0};
    @(negedge clk);
    while (scalar_cmd_ready) @(negedge clk);
    @(posedge clk);
    apply_reset();
    @(negedge clk);
    expect_word("scalar_cmd_ready_o", 32'(scalar_cmd_ready), 32'd1);
    expect_word("vec_cmd_ready_o", 32'(vec_cmd_ready), 32'd1);
    expect_word("scalar_res_valid_o", 32'(scalar_res_valid), 32'd0);
    expect_word("vec_res_valid_o", 32'(vec_res_valid), 32'd0);
    expect_word("wb_req_o.cyc", 32'(wb_req.cyc), 32'd0);
    expect_word("wb_req_o.stb", 32'(wb_req.stb), 32'd0);
    @(posedge clk);
  endtask

  initial begin
    void'($urandom(Seed));
    rst              <= 1'b1;
    scalar_cmd_valid <= 1'b0;
    scalar_cmd       <= '0;
    vec_cmd_valid    <= 1'b0;
    vec_cmd          <= '0;
    apply_reset();
    test_scalar_round_trip();
    test_vector_fill();
    test_vector_sum();
    test_length_clip();
    test_concurrent_traffic();
    test_reset_state();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: sim/lsu_system_sva.sv
// Wishbone classic protocol assertions on the arbiter ports
// Bound to every wb_arbiter instance

`timescale 1ns/1ps

module lsu_system_sva import wb_pkg::*; (
  input logic    clk_i,
  input logic    rst_i,
  input wb_req_t m0_req_i,
  input wb_rsp_t m0_rsp_o,
  input wb_req_t m1_req_i,
  input wb_rsp_t m1_rsp_o,
  input wb_req_t s_req_o,
  input wb_rsp_t s_rsp_i
);

  // Strobe only inside a bus cycle
  stb_within_cyc: assert property (@(posedge clk_i) disable iff (rst_i)
    (!m0_req_i.stb || m0_req_i.cyc) && (!m1_req_i.stb || m1_req_i.cyc) &&
    (!s_req_o.stb || s_req_o.cyc))
    else $error("stb high without cyc");

  ack_to_active_master: assert property (@(posedge clk_i) disable iff (rst_i)
    (!m0_rsp_o.ack || (m0_req_i.cyc && m0_req_i.stb)) &&
    (!m1_rsp_o.ack || (m1_req_i.cyc && m1_req_i.stb)))
    else $error("ack to a master without an active strobe");

  // Address, data and direction held until the slave acks
  req_stable_until_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    s_req_o.stb && !s_rsp_i.ack |=> $stable(s_req_o))
    else $error("slave request changed before ack");

  ack_one_master: assert property (@(posedge clk_i) disable iff (rst_i)
    !(m0_rsp_o.ack && m1_rsp_o.ack))
    else $error("ack sent to both masters in one cycle");

endmodule

bind wb_arbiter lsu_system_sva lsu_system_sva_inst (
  .clk_i    (clk_i),
  .rst_i    (rst_i),
  .m0_req_i (m0_req_i),
  .m0_rsp_o (m0_rsp_o),
  .m1_req_i (m1_req_i),
  .m1_rsp_o (m1_rsp_o),
  .s_req_o  (s_req_o),
  .s_rsp_i  (s_rsp_i)
);

// File: sim/wb_mem_model.sv
// Wishbone classic memory slave for simulation
// Random wait states, peek and poke access for the testbench

`timescale 1ns/1ps

module wb_mem_model import wb_pkg::*; #(
  parameter int unsigned Words = 4096
) (
  input  logic    clk_i,
  input  logic    rst_i,
  input  wb_req_t req_i,
  output wb_rsp_t rsp_o
);

  localparam int unsigned IdxWidth = $clog2(Words);

  logic [DataWidth-1:0] mem [Words];
  logic                 ack_q;
  logic [DataWidth-1:0] dat_q;
  // Wait states left before the next ack
  logic [1:0]           wait_q;
  logic [IdxWidth-1:0]  idx;

  assign idx       = req_i.adr[IdxWidth-1:0];
  assign rsp_o.ack = ack_q;
  assign rsp_o.dat = dat_q;

  initial begin
    for (int i = 0; i < Words; i++) begin
      mem[IdxWidth'(i)] <= 32'h5a00_0000 | 32'(i);
    end
  end

  always @(posedge clk_i) begin
    if (rst_i) begin
      ack_q  <= 1'b0;
      wait_q <= 2'd0;
    end else begin
      ack_q <= 1'b0;
      // One ack per transfer, never two in a row
      if (req_i.cyc && req_i.stb && !ack_q) begin
        if (wait_q == 2'd0) begin
          ack_q  <= 1'b1;
          wait_q <= 2'($urandom);
          if (req_i.we) begin
            mem[idx] <= req_i.dat;
          end else begin
            dat_q <= mem[idx];
          end
        end else begin
          wait_q <= wait_q - 2'd1;
        end
      end
    end
  end

  function automatic logic [DataWidth-1:0] peek_word(input logic [AddrWidth-1:0] addr);
    return mem[addr[IdxWidth-1:0]];
  endfunction

  task automatic poke_word(input logic [AddrWidth-1:0] addr, input logic [DataWidth-1:0] data);
    mem[addr[IdxWidth-1:0]] <= data;
  endtask

endmodule

// File: source/lsu_system.sv
// Memory subsystem top level
// Scalar and vector engines sharing one Wishbone port through an arbiter

`timescale 1ns/1ps

module lsu_system import wb_pkg::*, lsu_pkg::*; #(
  parameter int unsigned MaxVecLen = 64
) (
  input  logic        clk_i,
  input  logic        rst_i,
  // Scalar engine
  input  logic        scalar_cmd_valid_i,
  input  scalar_cmd_t scalar_cmd_i,
  output logic        scalar_cmd_ready_o,
  output logic        scalar_res_valid_o,
  output scalar_res_t scalar_res_o,
  // Vector engine
  input  logic        vec_cmd_valid_i,
  input  vec_cmd_t    vec_cmd_i,
  output logic        vec_cmd_ready_o,
  output logic        vec_res_valid_o,
  output vec_res_t    vec_res_o,
  // Memory bus
  output wb_req_t     wb_req_o,
  input  wb_rsp_t     wb_rsp_i
);

  wb_req_t scalar_req;
  wb_rsp_t scalar_rsp;
  wb_req_t vec_req;
  wb_rsp_t vec_rsp;

  // Master 0
  scalar_lsu scalar_lsu_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (scalar_cmd_valid_i),
    .cmd_i       (scalar_cmd_i),
    .cmd_ready_o (scalar_cmd_ready_o),
    .res_valid_o (scalar_res_valid_o),
    .res_o       (scalar_res_o),
    .wb_req_o    (scalar_req),
    .wb_rsp_i    (scalar_rsp)
  );

  // Master 1
  vector_lsu #(
    .MaxVecLen (MaxVecLen)
  ) vector_lsu_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cmd_valid_i (vec_cmd_valid_i),
    .cmd_i       (vec_cmd_i),
    .cmd_ready_o (vec_cmd_ready_o),
    .res_valid_o (vec_res_valid_o),
    .res_o       (vec_res_o),
    .wb_req_o    (vec_req),
    .wb_rsp_i    (vec_rsp)
  );

  wb_arbiter wb_arbiter_inst (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .m0_req_i (scalar_req),
    .m0_rsp_o (scalar_rsp),
    .m1_req_i (vec_req),
    .m1_rsp_o (vec_rsp),
    .s_req_o  (wb_req_o),
    .s_rsp_i  (wb_rsp_i)
  );

endmodule

// File: source/wb_arbiter.sv
// Two-master Wishbone classic arbiter
// Registered one-hot grant, round-robin on a free bus

`timescale 1ns/1ps

module wb_arbiter import wb_pkg::*; (
  input  logic    clk_i,
  input  logic    rst_i,
  // Master 0
  input  wb_req_t m0_req_i,
  output wb_rsp_t m0_rsp_o,
  // Master 1
  input  wb_req_t m1_req_i,
  output wb_rsp_t m1_rsp_o,
  // Slave side
  output wb_req_t s_req_o,
  input  wb_rsp_t s_rsp_i
);

  logic [1:0] gnt_q;
  logic       last_q;

  logic       owner_cyc;
  logic       bus_free;
  logic       any_req;
  logic       winner;
  logic [1:0] gnt_nxt;

  //////////////////////////////////////////////////////////////////////
  // Grant decision
  //////////////////////////////////////////////////////////////////////

  // Owner keeps the bus while its cyc stays high
  assign owner_cyc = (gnt_q[0] & m0_req_i.cyc) | (gnt_q[1] & m1_req_i.cyc);
  assign bus_free  = !owner_cyc;
  assign any_req   = m0_req_i.cyc | m1_req_i.cyc;

  // On a tie the master not served last wins
  always_comb begin
    if (m0_req_i.cyc && m1_req_i.cyc) begin
      winner = ~last_q;
    end else begin
      winner = m1_req_i.cyc;
    end
    gnt_nxt = any_req ? {winner, ~winner} : 2'b00;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      gnt_q  <= 2'b00;
      // Master 0 wins the first tie
      last_q <= 1'b1;
    end else if (bus_free) begin
      gnt_q <= gnt_nxt;
      if (any_req) begin
        last_q <= winner;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Request and response routing
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    s_req_o = gnt_q[1] ? m1_req_i : m0_req_i;
    // No owner, no bus cycle
    if (gnt_q == 2'b00) begin
      s_req_o.cyc = 1'b0;
      s_req_o.stb = 1'b0;
    end
  end

  // Read data goes to both, ack only to the owner
  assign m0_rsp_o.dat = s_rsp_i.dat;
  assign m1_rsp_o.dat = s_rsp_i.dat;
  assign m0_rsp_o.ack = s_rsp_i.ack & gnt_q[0];
  assign m1_rsp_o.ack = s_rsp_i.ack & gnt_q[1];

endmodule

// File: source/vector_lsu.sv
// Vector load/store engine
// Fill a run of words with seed plus index, or read a run and sum it
// Holds cyc for the whole run as one Wishbone block cycle

`timescale 1ns/1ps

module vector_lsu import wb_pkg::*, lsu_pkg::*; #(
  parameter int unsigned MaxVecLen = 64
) (
  input  logic     clk_i,
  input  logic     rst_i,
  // Command and result
  input  logic     cmd_valid_i,
  input  vec_cmd_t cmd_i,
  output logic     cmd_ready_o,
  output logic     res_valid_o,
  output vec_res_t res_o,
  // Wishbone master
  output wb_req_t  wb_req_o,
  input  wb_rsp_t  wb_rsp_i
);

  // Longest run, limited to what the 8-bit len can express
  localparam logic [7:0] MaxLen = (MaxVecLen > 255) ? 8'd255 : 8'(MaxVecLen);

  typedef enum logic [1:0] {
    StIdle,
    StBus,
    StDone
  } state_e;

  state_e               state_q;
  wb_req_t              req_q;
  logic [7:0]           idx_q;
  logic [7:0]           last_q;
  logic [DataWidth-1:0] seed_q;
  logic [DataWidth-1:0] sum_q;

  logic [7:0] len_clip;
  logic [7:0] idx_nxt;

  //////////////////////////////////////////////////////////////////////
  // Command side
  //////////////////////////////////////////////////////////////////////

  assign len_clip = (cmd_i.len > MaxLen) ? MaxLen : cmd_i.len;
  assign idx_nxt  = idx_q + 8'd1;

  assign cmd_ready_o = (state_q == StIdle);
  assign res_valid_o = (state_q == StDone);
  assign res_o.sum   = sum_q;
  assign wb_req_o    = req_q;

  //////////////////////////////////////////////////////////////////////
  // Run sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= StIdle;
      req_q.cyc <= 1'b0;
      req_q.stb <= 1'b0;
    end else begin
      case (state_q)
        StIdle: begin
          if (cmd_valid_i) begin
            req_q.cyc <= 1'b1;
            req_q.stb <= 1'b1;
            req_q.we  <= (cmd_i.op == VEC_FILL);
            req_q.adr <= cmd_i.base;
            // Word 0 of the fill pattern
            req_q.dat <= cmd_i.seed;
            seed_q    <= cmd_i.seed;
            idx_q     <= 8'd0;
            last_q    <= len_clip - 8'd1;
            sum_q     <= '0;
            state_q   <= StBus;
          end
        end
        StBus: begin
          if (wb_rsp_i.ack) begin
            // A fill leaves the sum at zero
            if (!req_q.we) begin
              sum_q <= sum_q + wb_rsp_i.dat;
            end
            if (idx_q == last_q) begin
              req_q.cyc <= 1'b0;
              req_q.stb <= 1'b0;
              state_q   <= StDone;
            end else begin
              // Next word follows directly, stb stays high
              idx_q     <= idx_nxt;
              req_q.adr <= req_q.adr + AddrWidth'(1);
              req_q.dat <= seed_q + DataWidth'(idx_nxt);
            end
          end
        end
        StDone: begin
          state_q <= StIdle;
        end
        default: begin
          state_q <= StIdle;
        end
      endcase
    end
  end

endmodule

// File: source/scalar_lsu.sv
// Scalar load/store engine
// One Wishbone classic transfer per command, result pulse after ack

`timescale 1ns/1ps

module scalar_lsu import wb_pkg::*, lsu_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_i,
  // Command and result
  input  logic        cmd_valid_i,
  input  scalar_cmd_t cmd_i,
  output logic        cmd_ready_o,
  output logic        res_valid_o,
  output scalar_res_t res_o,
  // Wishbone master
  output wb_req_t     wb_req_o,
  input  wb_rsp_t     wb_rsp_i
);

  typedef enum logic [1:0] {
    StIdle,
    StBus,
    StResp
  } state_e;

  state_e               state_q;
  wb_req_t              req_q;
  logic [DataWidth-1:0] rdata_q;

  assign cmd_ready_o = (state_q == StIdle);
  assign res_valid_o = (state_q == StResp);
  assign res_o.rdata = rdata_q;

  // Registered request, stable while stb is high
  assign wb_req_o = req_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q   <= StIdle;
      req_q.cyc <= 1'b0;
      req_q.stb <= 1'b0;
    end else begin
      case (state_q)
        StIdle: begin
          if (cmd_valid_i) begin
            req_q.cyc <= 1'b1;
            req_q.stb <= 1'b1;
            req_q.we  <= (cmd_i.op == SCALAR_STORE);
            req_q.adr <= cmd_i.addr;
            req_q.dat <= cmd_i.wdata;
            state_q   <= StBus;
          end
        end
        StBus: begin
          // Ack only arrives once the arbiter has granted us
          if (wb_rsp_i.ack) begin
            req_q.cyc <= 1'b0;
            req_q.stb <= 1'b0;
            if (!req_q.we) begin
              rdata_q <= wb_rsp_i.dat;
            end
            state_q <= StResp;
          end
        end
        StResp: begin
          state_q <= StIdle;
        end
        default: begin
          state_q <= StIdle;
        end
      endcase
    end
  end

endmodule

// File: source/lsu_pkg.sv
// Command and result structs of the scalar and vector engines
// Operation codes of both engines

package lsu_pkg;

  import wb_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Scalar engine
  //////////////////////////////////////////////////////////////////////

  typedef enum logic {
    SCALAR_LOAD,
    SCALAR_STORE
  } scalar_op_e;

  typedef struct packed {
    scalar_op_e           op;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
  } scalar_cmd_t;

  typedef struct packed {
    logic [DataWidth-1:0] rdata;
  } scalar_res_t;

  //////////////////////////////////////////////////////////////////////
  // Vector engine
  //////////////////////////////////////////////////////////////////////

  typedef enum logic {
    VEC_FILL,
    VEC_SUM
  } vec_op_e;

  // Run of len words from base, len 1 to 255
  typedef struct packed {
    vec_op_e              op;
    logic [AddrWidth-1:0] base;
    logic [7:0]           len;
    logic [DataWidth-1:0] seed;
  } vec_cmd_t;

  typedef struct packed {
    logic [DataWidth-1:0] sum;
  } vec_res_t;

endpackage

// File: source/wb_pkg.sv
// Wishbone classic bus widths
// Master request and slave response structs

package wb_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus widths
  //////////////////////////////////////////////////////////////////////

  // Word address, not byte address
  localparam int unsigned AddrWidth = 16;
  localparam int unsigned DataWidth = 32;

  //////////////////////////////////////////////////////////////////////
  // Bus structs
  //////////////////////////////////////////////////////////////////////

  // Driven by a master
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [AddrWidth-1:0] adr;
    logic [DataWidth-1:0] dat;
  } wb_req_t;

  // Returned by the slave
  typedef struct packed {
    logic                 ack;
    logic [DataWidth-1:0] dat;
  } wb_rsp_t;

endpackage
